//--- common/rv_isa.svh
// ========================================
// casez match patterns for the RV32IM subset
// included by the decoder
// ========================================
`ifndef RV_ISA_SVH
`define RV_ISA_SVH

`define rv32_lui    32'b????????????????????_?????_0110111
`define rv32_auipc  32'b????????????????????_?????_0010111
`define rv32_jal    32'b????????????????????_?????_1101111
`define rv32_jalr   32'b????????????_?????_000_?????_1100111

// conditional branches
`define rv32_beq    32'b???????_?????_?????_000_?????_1100011
`define rv32_bne    32'b???????_?????_?????_001_?????_1100011
`define rv32_blt    32'b???????_?????_?????_100_?????_1100011
`define rv32_bge    32'b???????_?????_?????_101_?????_1100011
`define rv32_bltu   32'b???????_?????_?????_110_?????_1100011
`define rv32_bgeu   32'b???????_?????_?????_111_?????_1100011

// loads and stores
`define rv32_lb     32'b????????????_?????_000_?????_0000011
`define rv32_lh     32'b????????????_?????_001_?????_0000011
`define rv32_lw     32'b????????????_?????_010_?????_0000011
`define rv32_lbu    32'b????????????_?????_100_?????_0000011
`define rv32_lhu    32'b????????????_?????_101_?????_0000011
`define rv32_sb     32'b???????_?????_?????_000_?????_0100011
`define rv32_sh     32'b???????_?????_?????_001_?????_0100011
`define rv32_sw     32'b???????_?????_?????_010_?????_0100011

// OP-IMM
`define rv32_addi   32'b????????????_?????_000_?????_0010011
`define rv32_slti   32'b????????????_?????_010_?????_0010011
`define rv32_sltiu  32'b????????????_?????_011_?????_0010011
`define rv32_xori   32'b????????????_?????_100_?????_0010011
`define rv32_ori    32'b????????????_?????_110_?????_0010011
`define rv32_andi   32'b????????????_?????_111_?????_0010011
`define rv32_slli   32'b0000000_?????_?????_001_?????_0010011
`define rv32_srli   32'b0000000_?????_?????_101_?????_0010011
`define rv32_srai   32'b0100000_?????_?????_101_?????_0010011

// OP
`define rv32_add    32'b0000000_?????_?????_000_?????_0110011
`define rv32_sub    32'b0100000_?????_?????_000_?????_0110011
`define rv32_sll    32'b0000000_?????_?????_001_?????_0110011
`define rv32_slt    32'b0000000_?????_?????_010_?????_0110011
`define rv32_sltu   32'b0000000_?????_?????_011_?????_0110011
`define rv32_xor    32'b0000000_?????_?????_100_?????_0110011
`define rv32_srl    32'b0000000_?????_?????_101_?????_0110011
`define rv32_sra    32'b0100000_?????_?????_101_?????_0110011
`define rv32_or     32'b0000000_?????_?????_110_?????_0110011
`define rv32_and    32'b0000000_?????_?????_111_?????_0110011

// M extension, multiplies only
`define rv32_mul    32'b0000001_?????_?????_000_?????_0110011
`define rv32_mulh   32'b0000001_?????_?????_001_?????_0110011
`define rv32_mulhsu 32'b0000001_?????_?????_010_?????_0110011
`define rv32_mulhu  32'b0000001_?????_?????_011_?????_0110011

// system
`define rv32_csrrw  32'b????????????_?????_001_?????_1110011
`define rv32_csrrs  32'b????????????_?????_010_?????_1110011
`define rv32_csrrc  32'b????????????_?????_011_?????_1110011
`define wfi         32'b000100000101_00000_000_00000_1110011

`endif

//--- common/rv_decode_pkg.sv
// ========================================
// shared types for the RV32IM decode stage
// import wherever instruction or packet types are needed
// ========================================
`default_nettype none

package rv_decode_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] addr_t;
    typedef logic [4:0]      arch_reg_idx_t;

    // instruction format views, all 32 bits wide
    typedef struct packed {
        logic [6:0]    funct7;
        arch_reg_idx_t rs2;
        arch_reg_idx_t rs1;
        logic [2:0]    funct3;
        arch_reg_idx_t rd;
        logic [6:0]    opcode;
    } r_inst_t;

    typedef struct packed {
        logic [11:0]   imm;
        arch_reg_idx_t rs1;
        logic [2:0]    funct3;
        arch_reg_idx_t rd;
        logic [6:0]    opcode;
    } i_inst_t;

    typedef struct packed {
        logic [6:0]    imm_hi;
        arch_reg_idx_t rs2;
        arch_reg_idx_t rs1;
        logic [2:0]    funct3;
        logic [4:0]    imm_lo;
        logic [6:0]    opcode;
    } s_inst_t;

    typedef struct packed {
        logic          imm12;
        logic [5:0]    imm10_5;
        arch_reg_idx_t rs2;
        arch_reg_idx_t rs1;
        logic [2:0]    funct3;
        logic [3:0]    imm4_1;
        logic          imm11;
        logic [6:0]    opcode;
    } b_inst_t;

    typedef struct packed {
        logic [19:0]   imm;
        arch_reg_idx_t rd;
        logic [6:0]    opcode;
    } u_inst_t;

    typedef struct packed {
        logic          imm20;
        logic [9:0]    imm10_1;
        logic          imm11;
        logic [7:0]    imm19_12;
        arch_reg_idx_t rd;
        logic [6:0]    opcode;
    } j_inst_t;

    typedef union packed {
        r_inst_t r;
        i_inst_t i;
        s_inst_t s;
        b_inst_t b;
        u_inst_t u;
        j_inst_t j;
    } inst_t;

    typedef enum logic [1:0] {
        opa_is_rs1,
        opa_is_pc,
        opa_is_zero
    } opa_select_t;

    typedef enum logic [2:0] {
        opb_is_rs2,
        opb_is_i_imm,
        opb_is_s_imm,
        opb_is_b_imm,
        opb_is_u_imm,
        opb_is_j_imm
    } opb_select_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra
    } alu_func_t;

    typedef enum logic [1:0] {
        fu_alu,
        fu_mult,
        fu_ldst,
        fu_bu
    } fu_type_t;

    typedef struct packed {
        inst_t inst;
        addr_t pc;
    } fetch_entry_t;

    typedef struct packed {
        inst_t       inst;
        addr_t       pc;
        addr_t       npc;
        logic        valid;
        opa_select_t opa_select;
        opb_select_t opb_select;
        alu_func_t   alu_func;
        logic        has_dest;
        logic        csr_op;
        logic        mult;
        logic        rd_mem;
        logic        wr_mem;
        logic        cond_branch;
        logic        uncond_branch;
        logic        halt;
        logic        illegal;
        fu_type_t    fu_type;
    } decode_packet_t;

endpackage

`default_nettype wire

//--- common/reg_use_if.sv
// ========================================
// register usage of the decoded instruction
// decoder drives it, busy table checks and updates from it
// ========================================
`default_nettype none

interface reg_use_if;
    import rv_decode_pkg::*;

    logic          rs1_used;
    logic          rs2_used;
    arch_reg_idx_t src1;
    arch_reg_idx_t src2;
    arch_reg_idx_t dest;
    logic          has_dest;

    modport producer (output rs1_used, rs2_used, src1, src2, dest, has_dest);
    modport consumer (input rs1_used, rs2_used, src1, src2, dest, has_dest);
endinterface

`default_nettype wire

//--- src/sync_fifo.sv
// ========================================
// synchronous FIFO, payload type set per instance
// head is visible combinationally while not empty
// ========================================
`default_nettype none

module sync_fifo #(
    parameter int  depth     = 4,
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head,
    output logic     empty,
    output logic     full
);
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t         mem [depth];
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w-1:0] wr_ptr;
    logic [cnt_w-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign empty   = (count == '0);
    assign full    = (count == cnt_w'(depth));
    assign do_pop  = pop && !empty;
    // a pop in the same cycle frees the slot
    assign do_push = push && (!full || do_pop);
    assign head    = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- decode/decoder.sv
// ========================================
// combinational RV32IM decoder
// builds the decode packet and register usage from one fetch entry
// ========================================
`default_nettype none
`include "rv_isa.svh"

module decoder (
    input  rv_decode_pkg::inst_t          inst,
    // low means no instruction, the packet then looks like a NOP
    input  logic                          valid,
    input  rv_decode_pkg::addr_t          pc,
    output rv_decode_pkg::decode_packet_t decoder_out,
    reg_use_if.producer                   reg_use
);
    import rv_decode_pkg::*;

    // ALU function shared by OP and OP-IMM, alt is inst bit 30
    function automatic alu_func_t alu_of(input logic [2:0] funct3, input logic alt,
                                         input logic imm);
        case (funct3)
            3'b000:  alu_of = (alt && !imm) ? alu_sub : alu_add;
            3'b001:  alu_of = alu_sll;
            3'b010:  alu_of = alu_slt;
            3'b011:  alu_of = alu_sltu;
            3'b100:  alu_of = alu_xor;
            3'b101:  alu_of = alt ? alu_sra : alu_srl;
            3'b110:  alu_of = alu_or;
            default: alu_of = alu_and;
        endcase
    endfunction

    always_comb begin
        decoder_out.inst          = inst;
        decoder_out.pc            = pc;
        decoder_out.npc           = pc + 32'd4;
        decoder_out.valid         = valid;
        // NOP defaults
        decoder_out.opa_select    = opa_is_rs1;
        decoder_out.opb_select    = opb_is_rs2;
        decoder_out.alu_func      = alu_add;
        decoder_out.has_dest      = 1'b0;
        decoder_out.csr_op        = 1'b0;
        decoder_out.mult          = 1'b0;
        decoder_out.rd_mem        = 1'b0;
        decoder_out.wr_mem        = 1'b0;
        decoder_out.cond_branch   = 1'b0;
        decoder_out.uncond_branch = 1'b0;
        decoder_out.halt          = 1'b0;
        decoder_out.illegal       = 1'b0;

        if (valid) begin
            casez (inst)
                `rv32_lui: begin
                    decoder_out.has_dest   = 1'b1;
                    decoder_out.opa_select = opa_is_zero;
                    decoder_out.opb_select = opb_is_u_imm;
                end
                `rv32_auipc: begin
                    decoder_out.has_dest   = 1'b1;
                    decoder_out.opa_select = opa_is_pc;
                    decoder_out.opb_select = opb_is_u_imm;
                end
                `rv32_jal: begin
                    decoder_out.has_dest      = 1'b1;
                    decoder_out.opa_select    = opa_is_pc;
                    decoder_out.opb_select    = opb_is_j_imm;
                    decoder_out.uncond_branch = 1'b1;
                end
                `rv32_jalr: begin
                    decoder_out.has_dest      = 1'b1;
                    decoder_out.opb_select    = opb_is_i_imm;
                    decoder_out.uncond_branch = 1'b1;
                end
                `rv32_beq, `rv32_bne, `rv32_blt, `rv32_bge, `rv32_bltu, `rv32_bgeu: begin
                    // compare type is taken from funct3 downstream
                    decoder_out.opa_select  = opa_is_pc;
                    decoder_out.opb_select  = opb_is_b_imm;
                    decoder_out.cond_branch = 1'b1;
                end
                `rv32_lb, `rv32_lh, `rv32_lw, `rv32_lbu, `rv32_lhu: begin
                    decoder_out.has_dest   = 1'b1;
                    decoder_out.opb_select = opb_is_i_imm;
                    decoder_out.rd_mem     = 1'b1;
                end
                `rv32_sb, `rv32_sh, `rv32_sw: begin
                    decoder_out.opb_select = opb_is_s_imm;
                    decoder_out.wr_mem     = 1'b1;
                end
                `rv32_addi, `rv32_slti, `rv32_sltiu, `rv32_xori, `rv32_ori, `rv32_andi,
                `rv32_slli, `rv32_srli, `rv32_srai: begin
                    decoder_out.has_dest   = 1'b1;
                    decoder_out.opb_select = opb_is_i_imm;
                    decoder_out.alu_func   = alu_of(inst.r.funct3, inst.r.funct7[5], 1'b1);
                end
                `rv32_add, `rv32_sub, `rv32_sll, `rv32_slt, `rv32_sltu,
                `rv32_xor, `rv32_srl, `rv32_sra, `rv32_or, `rv32_and: begin
                    decoder_out.has_dest = 1'b1;
                    decoder_out.alu_func = alu_of(inst.r.funct3, inst.r.funct7[5], 1'b0);
                end
                `rv32_mul, `rv32_mulh, `rv32_mulhsu, `rv32_mulhu: begin
                    // multiply variant is funct3
                    decoder_out.has_dest = 1'b1;
                    decoder_out.mult     = 1'b1;
                end
                `rv32_csrrw, `rv32_csrrs, `rv32_csrrc: begin
                    decoder_out.csr_op = 1'b1;
                end
                `wfi: begin
                    decoder_out.halt = 1'b1;
                end
                default: begin
                    decoder_out.illegal = 1'b1;
                end
            endcase
        end

        decoder_out.fu_type = (decoder_out.cond_branch || decoder_out.uncond_branch) ? fu_bu :
                              (decoder_out.rd_mem || decoder_out.wr_mem)             ? fu_ldst :
                              decoder_out.mult                                       ? fu_mult :
                                                                                       fu_alu;
    end

    // stores read rs2 as data even though opb is the immediate
    assign reg_use.rs1_used = decoder_out.cond_branch || (decoder_out.opa_select == opa_is_rs1);
    assign reg_use.rs2_used = decoder_out.cond_branch || decoder_out.wr_mem ||
                              (decoder_out.opb_select == opb_is_rs2);
    assign reg_use.src1     = inst.r.rs1;
    assign reg_use.src2     = inst.r.rs2;
    assign reg_use.dest     = inst.r.rd;
    assign reg_use.has_dest = decoder_out.has_dest;

endmodule

`default_nettype wire

//--- decode/busy_table.sv
// ========================================
// busy bits for registers with a pending result
// flags a hazard when a used source is still busy
// ========================================
`default_nettype none

module busy_table (
    input  logic                         clk,
    input  logic                         arst_n,
    reg_use_if.consumer                  reg_use,
    input  logic                         fire,
    input  logic                         cmpl_valid,
    input  rv_decode_pkg::arch_reg_idx_t cmpl_reg,
    output logic                         hazard
);
    import rv_decode_pkg::*;

    logic [31:0] busy;
    logic        src1_busy;
    logic        src2_busy;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= '0;
        end else begin
            if (cmpl_valid) begin
                busy[cmpl_reg] <= 1'b0;
            end
            // set comes last so it wins over a clear of the same register
            if (fire && reg_use.has_dest && (reg_use.dest != '0)) begin
                busy[reg_use.dest] <= 1'b1;
            end
        end
    end

    // a source of x0 never raises a hazard
    assign src1_busy = reg_use.rs1_used && (reg_use.src1 != '0) && busy[reg_use.src1];
    assign src2_busy = reg_use.rs2_used && (reg_use.src2 != '0) && busy[reg_use.src2];
    assign hazard    = src1_busy || src2_busy;

endmodule

`default_nettype wire

//--- src/decode_stage.sv
// ========================================
// decode stage top: fetch queue, decoder, busy table, dispatch queue
// fires one instruction per cycle when no hazard or stall holds it
// ========================================
`default_nettype none

module decode_stage #(
    parameter int fetch_depth    = 4,
    parameter int dispatch_depth = 4
) (
    input  logic                          clk,
    input  logic                          arst_n,
    // fetch side
    input  logic                          inst_push,
    input  rv_decode_pkg::inst_t          push_inst,
    input  rv_decode_pkg::addr_t          push_pc,
    output logic                          fetch_full,
    // dispatch side
    input  logic                          dispatch_pop,
    output logic                          dispatch_valid,
    output rv_decode_pkg::decode_packet_t dispatch_pkt,
    // writeback completion
    input  logic                          cmpl_valid,
    input  rv_decode_pkg::arch_reg_idx_t  cmpl_reg,
    output logic                          halted
);
    import rv_decode_pkg::*;

    fetch_entry_t   fetch_in;
    fetch_entry_t   fetch_head;
    logic           fetch_empty;
    decode_packet_t dec_pkt;
    logic           dispatch_empty;
    logic           dispatch_full;
    logic           hazard;
    logic           fire;

    reg_use_if reg_use ();

    assign fetch_in = '{inst: push_inst, pc: push_pc};

    sync_fifo #(.depth(fetch_depth), .payload_t(fetch_entry_t)) fetch_q (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (inst_push),
        .push_data (fetch_in),
        .pop       (fire),
        .head      (fetch_head),
        .empty     (fetch_empty),
        .full      (fetch_full)
    );

    decoder u_decoder (
        .inst        (fetch_head.inst),
        .valid       (!fetch_empty),
        .pc          (fetch_head.pc),
        .decoder_out (dec_pkt),
        .reg_use     (reg_use.producer)
    );

    busy_table busy_tbl (
        .clk        (clk),
        .arst_n     (arst_n),
        .reg_use    (reg_use.consumer),
        .fire       (fire),
        .cmpl_valid (cmpl_valid),
        .cmpl_reg   (cmpl_reg),
        .hazard     (hazard)
    );

    sync_fifo #(.depth(dispatch_depth), .payload_t(decode_packet_t)) dispatch_q (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (fire),
        .push_data (dec_pkt),
        .pop       (dispatch_pop),
        .head      (dispatch_pkt),
        .empty     (dispatch_empty),
        .full      (dispatch_full)
    );

    // head moves only with room downstream and its sources ready
    assign fire           = !fetch_empty && !dispatch_full && !halted && !hazard;
    assign dispatch_valid = !dispatch_empty;

    // WFI stops the stage until reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            halted <= 1'b0;
        end else if (fire && dec_pkt.halt) begin
            halted <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- test/decode_stage_sva.sv
// ========================================
// assertions on fire, halt and busy table behavior
// bound into decode_stage
// ========================================
`default_nettype none

module decode_stage_sva (
    input logic clk,
    input logic arst_n,
    input logic fire,
    input logic hazard,
    input logic halted,
    input logic dispatch_valid,
    input logic x0_busy
);
    timeunit 1ns;
    timeprecision 1ps;

    no_fire_when_halted: assert property (@(posedge clk) disable iff (!arst_n)
        halted |-> !fire)
        else $error("instruction fired while halted");

    // first edge out of reset sees an empty dispatch queue
    empty_after_reset: assert property (@(posedge clk)
        $rose(arst_n) |-> !dispatch_valid)
        else $error("dispatch_valid high right after reset");

    x0_never_busy: assert property (@(posedge clk) disable iff (!arst_n)
        !x0_busy)
        else $error("x0 marked busy");

    no_fire_on_hazard: assert property (@(posedge clk) disable iff (!arst_n)
        !(fire && hazard))
        else $error("instruction fired with a source hazard");

endmodule

bind decode_stage decode_stage_sva sva_chk (
    .clk            (clk),
    .arst_n         (arst_n),
    .fire           (fire),
    .hazard         (hazard),
    .halted         (halted),
    .dispatch_valid (dispatch_valid),
    .x0_busy        (busy_tbl.busy[0])
);

`default_nettype wire

//--- test/decode_stage_tb.sv
// ========================================
// testbench for the decode stage
// runs the command lines of test/decode_stimulus.txt and checks each dispatched packet
// ========================================
`default_nettype none

module decode_stage_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import rv_decode_pkg::*;

    localparam int fetch_depth    = 4;
    localparam int dispatch_depth = 4;
    localparam int pop_timeout    = 50;

    // one expected packet as given on a push line
    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] pc;
        logic [1:0]  fu;
        logic [3:0]  alu;
        logic [1:0]  opa;
        logic [2:0]  opb;
        logic [8:0]  flags;
    } exp_pkt_t;

    logic           clk;
    logic           arst_n;
    logic           inst_push;
    inst_t          push_inst;
    addr_t          push_pc;
    logic           fetch_full;
    logic           dispatch_pop;
    logic           dispatch_valid;
    decode_packet_t dispatch_pkt;
    logic           cmpl_valid;
    arch_reg_idx_t  cmpl_reg;
    logic           halted;

    exp_pkt_t exp_q[$];
    string    test_name;
    int       test_errors;
    int       errors;
    int       checks;
    int       tests;

    decode_stage #(
        .fetch_depth    (fetch_depth),
        .dispatch_depth (dispatch_depth)
    ) UUT (
        .clk            (clk),
        .arst_n         (arst_n),
        .inst_push      (inst_push),
        .push_inst      (push_inst),
        .push_pc        (push_pc),
        .fetch_full     (fetch_full),
        .dispatch_pop   (dispatch_pop),
        .dispatch_valid (dispatch_valid),
        .dispatch_pkt   (dispatch_pkt),
        .cmpl_valid     (cmpl_valid),
        .cmpl_reg       (cmpl_reg),
        .halted         (halted)
    );

    always #5 clk = ~clk;

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            $display("FAILED %s: %s expected %h actual %h", test_name, what, expected, actual);
            test_errors++;
            errors++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("ERROR in test %s: %s", test_name, msg);
        test_errors++;
        errors++;
    endtask

    task automatic finish_test();
        if (test_name.len() > 0) begin
            $display("test %s finished with %0d errors", test_name, test_errors);
            tests++;
        end
    endtask

    task automatic apply_reset();
        arst_n = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    endtask

    task automatic push_entry(input logic [31:0] inst, input logic [31:0] pc);
        @(negedge clk);
        inst_push = 1'b1;
        push_inst = inst;
        push_pc   = pc;
        @(negedge clk);
        inst_push = 1'b0;
    endtask

    task automatic complete_reg(input arch_reg_idx_t r);
        @(negedge clk);
        cmpl_valid = 1'b1;
        cmpl_reg   = r;
        @(negedge clk);
        cmpl_valid = 1'b0;
    endtask

    // dispatch queue has to stay empty for n cycles
    task automatic expect_idle(input int n);
        repeat (n) begin
            @(negedge clk);
            check_value("dispatch_valid", 32'd0, 32'(dispatch_valid));
        end
    endtask

    task automatic pop_and_check();
        int          waited;
        exp_pkt_t    e;
        logic [8:0]  flags;
        waited = 0;
        @(negedge clk);
        while (!dispatch_valid && waited < pop_timeout) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() == 0) begin
            report_error("pop requested but no expected packet is left");
        end else if (!dispatch_valid) begin
            report_error("timed out waiting for dispatch_valid");
            void'(exp_q.pop_front());
        end else begin
            e = exp_q.pop_front();
            flags = {dispatch_pkt.has_dest, dispatch_pkt.csr_op, dispatch_pkt.mult,
                     dispatch_pkt.rd_mem, dispatch_pkt.wr_mem, dispatch_pkt.cond_branch,
                     dispatch_pkt.uncond_branch, dispatch_pkt.halt, dispatch_pkt.illegal};
            check_value("inst", e.inst, 32'(dispatch_pkt.inst));
            check_value("pc", e.pc, dispatch_pkt.pc);
            check_value("npc", e.pc + 32'd4, dispatch_pkt.npc);
            check_value("valid", 32'd1, 32'(dispatch_pkt.valid));
            check_value("fu_type", 32'(e.fu), 32'(dispatch_pkt.fu_type));
            check_value("alu_func", 32'(e.alu), 32'(dispatch_pkt.alu_func));
            check_value("opa_select", 32'(e.opa), 32'(dispatch_pkt.opa_select));
            check_value("opb_select", 32'(e.opb), 32'(dispatch_pkt.opb_select));
            check_value("flags", 32'(e.flags), 32'(flags));
            dispatch_pop = 1'b1;
            @(negedge clk);
            dispatch_pop = 1'b0;
        end
    endtask

    initial begin
        int            fd;
        int            rc;
        int            f_fu;
        int            f_alu;
        int            f_opa;
        int            f_opb;
        int            f_n;
        logic [255:0]  cmd;
        logic [1023:0] line;
        logic [31:0]   f_inst;
        logic [31:0]   f_pc;
        logic [8:0]    f_flags;
        exp_pkt_t      e;

        clk          = 1'b0;
        arst_n       = 1'b0;
        inst_push    = 1'b0;
        push_inst    = '0;
        push_pc      = '0;
        dispatch_pop = 1'b0;
        cmpl_valid   = 1'b0;
        cmpl_reg     = '0;
        test_name    = "";
        test_errors  = 0;
        errors       = 0;
        checks       = 0;
        tests        = 0;

        apply_reset();
        fd = $fopen("test/decode_stimulus.txt", "r");
        if (fd == 0) begin
            report_error("cannot open test/decode_stimulus.txt");
        end else begin
            while ($fscanf(fd, "%s", cmd) == 1) begin
                if (cmd == "#") begin
                    rc = $fgets(line, fd);
                end else if (cmd == "test") begin
                    rc = $fscanf(fd, "%s", cmd);
                    finish_test();
                    test_name   = $sformatf("%0s", cmd);
                    test_errors = 0;
                end else if (cmd == "reset") begin
                    apply_reset();
                    exp_q.delete();
                end else if (cmd == "push") begin
                    rc = $fscanf(fd, "%h %h %d %d %d %d %b", f_inst, f_pc, f_fu, f_alu,
                                 f_opa, f_opb, f_flags);
                    e.inst  = f_inst;
                    e.pc    = f_pc;
                    e.fu    = 2'(f_fu);
                    e.alu   = 4'(f_alu);
                    e.opa   = 2'(f_opa);
                    e.opb   = 3'(f_opb);
                    e.flags = f_flags;
                    exp_q.push_back(e);
                    push_entry(f_inst, f_pc);
                end else if (cmd == "drop") begin
                    // pushed but never expected at the dispatch side
                    rc = $fscanf(fd, "%h %h", f_inst, f_pc);
                    push_entry(f_inst, f_pc);
                end else if (cmd == "pop") begin
                    pop_and_check();
                end else if (cmd == "complete") begin
                    rc = $fscanf(fd, "%d", f_n);
                    complete_reg(5'(f_n));
                end else if (cmd == "idle") begin
                    rc = $fscanf(fd, "%d", f_n);
                    expect_idle(f_n);
                end else if (cmd == "full") begin
                    rc = $fscanf(fd, "%d", f_n);
                    @(negedge clk);
                    check_value("fetch_full", 32'(f_n), 32'(fetch_full));
                end else if (cmd == "halted") begin
                    rc = $fscanf(fd, "%d", f_n);
                    @(negedge clk);
                    check_value("halted", 32'(f_n), 32'(halted));
                end else begin
                    report_error("unknown command in the stimulus file");
                end
            end
            $fclose(fd);
        end
        finish_test();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test/decode_stimulus.txt
# push: inst pc fu alu opa opb flags / drop: inst pc / complete, idle: n / full, halted: 0 or 1
# fu alu0 mult1 ldst2 bu3, alu add0 sub1 xor6 sra9, opa rs1 0 pc1 zero2, opb rs2 0 i1 s2 b3 u4 j5
# flags: has_dest csr mult rd_mem wr_mem cond_br uncond_br halt illegal
test reset_state
idle 2
full 0
halted 0
test decode_classes
push 123450b7 00001000 0 0 2 4 100000000
pop
push 00001117 00001004 0 0 1 4 100000000
pop
push 008001ef 00001008 3 0 1 5 100000100
pop
push 000a0267 0000100c 3 0 0 1 100000100
pop
push 015a0463 00001010 3 0 1 3 000001000
pop
push 004a2283 00001014 2 0 0 1 100100000
pop
push 015a2423 00001018 2 0 0 2 000010000
pop
push 001a0313 0000101c 0 0 0 1 100000000
pop
push 403a5393 00001020 0 9 0 1 100000000
pop
push 415a0433 00001024 0 1 0 0 100000000
pop
push 017b44b3 00001028 0 6 0 0 100000000
pop
push 035a0533 0000102c 1 0 0 0 101000000
pop
push 300a1073 00001030 0 0 0 0 010000000
pop
test illegal_word
push 00000000 00002000 0 0 0 0 000000001
pop
test source_hazard
reset
push 005a0093 00002100 0 0 0 1 100000000
pop
# rs1 is x0 and the rs2 field names busy x1 but is unused
push 00100393 00002104 0 0 0 1 100000000
pop
push 00308133 00002108 0 0 0 0 100000000
idle 6
complete 1
pop
test order_backpressure
reset
push 00100013 00003000 0 0 0 1 100000000
push 00200013 00003004 0 0 0 1 100000000
push 00300013 00003008 0 0 0 1 100000000
push 00400013 0000300c 0 0 0 1 100000000
push 00500013 00003010 0 0 0 1 100000000
push 00600013 00003014 0 0 0 1 100000000
push 00700013 00003018 0 0 0 1 100000000
push 00800013 0000301c 0 0 0 1 100000000
full 1
drop 00900013 00003020
pop
pop
pop
pop
pop
pop
pop
pop
idle 5
full 0
test wfi_halt
reset
push 10500073 00004000 0 0 0 0 000000010
pop
halted 1
drop 00100013 00004004
idle 6
halted 1
reset
halted 0
push 00100013 00004008 0 0 0 1 100000000
pop

//--- flist.f
+incdir+common
common/rv_decode_pkg.sv
common/reg_use_if.sv
src/sync_fifo.sv
decode/decoder.sv
decode/busy_table.sv
src/decode_stage.sv
test/decode_stage_sva.sv
test/decode_stage_tb.sv

//--- run.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    -f flist.f --top-module decode_stage_tb -o decode_stage_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/decode_stage_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test completed successfully" "$log"; then
    exit 0
fi
exit 1
